// File: build.f
design/tcdm_pkg.sv
design/reorder_buffer.sv
design/addr_demux.sv
design/tcdm_bank.sv
design/tcdm_shim.sv
design/tcdm_subsystem.sv
tb/tcdm_checker.sv
tb/tb_tcdm.sv

// File: design/addr_demux.sv
/*
 * Address demultiplexer
 * Steers requests to a bank or the SoC and arbitrates returning responses
 */
`timescale 1ns/1ps

module addr_demux (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  tcdm_pkg::dreq_t                          req_i,
  input  logic                                     req_valid_i,
  output logic                                     req_ready_o,
  output tcdm_pkg::dresp_t                         resp_o,
  output logic                                     resp_valid_o,
  output tcdm_pkg::dreq_t  [tcdm_pkg::NumOutput-1:0] out_req_o,
  output logic             [tcdm_pkg::NumOutput-1:0] out_valid_o,
  input  logic             [tcdm_pkg::NumOutput-1:0] out_ready_i,
  input  tcdm_pkg::dresp_t [tcdm_pkg::NumOutput-1:0] out_resp_i,
  input  logic             [tcdm_pkg::NumOutput-1:0] out_resp_valid_i,
  output logic             [tcdm_pkg::NumOutput-1:0] out_resp_ready_o
);

  logic                 in_tcdm;
  tcdm_pkg::port_sel_t  sel;
  tcdm_pkg::bank_addr_t word_idx;

  // Requests in flight per output
  tcdm_pkg::rob_cnt_t [tcdm_pkg::NumOutput-1:0] pending_q;
  logic               [tcdm_pkg::NumOutput-1:0] req_fire;
  logic               [tcdm_pkg::NumOutput-1:0] resp_take;

  assign in_tcdm  = (req_i.addr - tcdm_pkg::TcdmBase) < tcdm_pkg::TcdmSize;
  assign word_idx = req_i.addr[tcdm_pkg::WordLsb +: $bits(tcdm_pkg::bank_addr_t)];

  always_comb begin
    if (in_tcdm) begin
      sel = tcdm_pkg::port_sel_t'(req_i.addr[tcdm_pkg::BankSelLsb +: tcdm_pkg::BankSelBits]);
    end else begin
      sel = tcdm_pkg::port_sel_t'(tcdm_pkg::SocPort);
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < tcdm_pkg::NumOutput; i++) begin
      out_req_o[i] = req_i;
      // Banks only see the word index
      if (i < tcdm_pkg::NumBanks) begin
        out_req_o[i].addr = tcdm_pkg::addr_t'(word_idx);
      end
      out_valid_o[i] = req_valid_i && (sel == tcdm_pkg::port_sel_t'(i));
    end
  end

  assign req_ready_o = out_ready_i[sel];
  assign req_fire    = out_valid_o & out_ready_i;

  // Fixed priority, lowest index first
  always_comb begin
    logic found;
    found            = 1'b0;
    resp_o           = '0;
    resp_valid_o     = 1'b0;
    out_resp_ready_o = '0;
    resp_take        = '0;
    for (int unsigned i = 0; i < tcdm_pkg::NumOutput; i++) begin
      if (out_resp_valid_i[i]) begin
        if (pending_q[i] == '0) begin
          // Nothing outstanding here, swallow the stray response
          out_resp_ready_o[i] = 1'b1;
        end else if (!found) begin
          found               = 1'b1;
          resp_o              = out_resp_i[i];
          resp_valid_o        = 1'b1;
          out_resp_ready_o[i] = 1'b1;
          resp_take[i]        = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      for (int unsigned i = 0; i < tcdm_pkg::NumOutput; i++) begin
        if (req_fire[i] && !resp_take[i]) begin
          pending_q[i] <= pending_q[i] + 1'b1;
        end else if (!req_fire[i] && resp_take[i]) begin
          pending_q[i] <= pending_q[i] - 1'b1;
        end
      end
    end
  end

endmodule

// File: design/reorder_buffer.sv
/*
 * Reorder buffer
 * Hands out tags and returns responses in allocation order, with fall-through
 */
`timescale 1ns/1ps

module reorder_buffer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              alloc_i,
  output tcdm_pkg::rob_id_t id_o,
  output logic              full_o,
  input  logic              push_i,
  input  tcdm_pkg::dresp_t  push_resp_i,
  output tcdm_pkg::dresp_t  resp_o,
  output logic              valid_o,
  input  logic              pop_i
);

  tcdm_pkg::rob_id_t  wr_ptr_q;
  tcdm_pkg::rob_id_t  rd_ptr_q;
  tcdm_pkg::rob_cnt_t count_q;
  logic [tcdm_pkg::RobDepth-1:0] filled_q;

  tcdm_pkg::data_t data_q [tcdm_pkg::RobDepth];
  logic            err_q  [tcdm_pkg::RobDepth];

  logic head_hit;
  logic pop;

  assign id_o   = wr_ptr_q;
  assign full_o = (count_q == tcdm_pkg::rob_cnt_t'(tcdm_pkg::RobDepth));

  // Push carrying the head tag bypasses the storage
  assign head_hit = push_i && (push_resp_i.id == rd_ptr_q);
  assign valid_o  = filled_q[rd_ptr_q] || head_hit;
  assign pop      = valid_o && pop_i;

  always_comb begin
    resp_o.id = rd_ptr_q;
    if (filled_q[rd_ptr_q]) begin
      resp_o.data  = data_q[rd_ptr_q];
      resp_o.error = err_q[rd_ptr_q];
    end else begin
      resp_o.data  = push_resp_i.data;
      resp_o.error = push_resp_i.error;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      filled_q <= '0;
    end else begin
      if (alloc_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (alloc_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!alloc_i && pop) begin
        count_q <= count_q - 1'b1;
      end
      // Slot stays empty when the push is delivered straight through
      if (push_i && !(head_hit && pop)) begin
        filled_q[push_resp_i.id] <= 1'b1;
      end
      if (pop && filled_q[rd_ptr_q]) begin
        filled_q[rd_ptr_q] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[push_resp_i.id] <= push_resp_i.data;
      err_q[push_resp_i.id]  <= push_resp_i.error;
    end
  end

endmodule

// File: design/tcdm_bank.sv
/*
 * TCDM bank
 * Word memory with byte strobes and a one-deep registered response
 */
`timescale 1ns/1ps

module tcdm_bank (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  tcdm_pkg::dreq_t  req_i,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  output tcdm_pkg::dresp_t resp_o,
  output logic             resp_valid_o,
  input  logic             resp_ready_i
);

  tcdm_pkg::data_t      mem_q [tcdm_pkg::BankWords];
  tcdm_pkg::bank_addr_t idx;
  tcdm_pkg::dresp_t     resp_q;
  logic                 resp_valid_q;
  logic                 req_fire;

  assign idx = req_i.addr[$bits(tcdm_pkg::bank_addr_t)-1:0];

  // Free slot, or the held response leaves this cycle
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q.data  <= req_i.write ? '0 : mem_q[idx];
      resp_q.id    <= req_i.id;
      resp_q.error <= 1'b0;
      if (req_i.write) begin
        for (int unsigned b = 0; b < $bits(tcdm_pkg::strb_t); b++) begin
          if (req_i.strb[b]) begin
            mem_q[idx][8*b +: 8] <= req_i.data[8*b +: 8];
          end
        end
      end
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

endmodule

// File: design/tcdm_pkg.sv
/*
 * TCDM shim package
 * Widths, request and response structs, and the fixed address map
 */
package tcdm_pkg;

  localparam int unsigned RobDepth  = 8;
  localparam int unsigned NumBanks  = 2;
  localparam int unsigned BankWords = 256;
  localparam int unsigned NumOutput = 3;
  // Last output is the SoC port
  localparam int unsigned SocPort   = NumOutput - 1;

  // Bank select sits just above the byte offset, word index above that
  localparam int unsigned BankSelLsb  = 2;
  localparam int unsigned BankSelBits = $clog2(NumBanks);
  localparam int unsigned WordLsb     = BankSelLsb + BankSelBits;

  typedef logic [31:0]                      addr_t;
  typedef logic [31:0]                      data_t;
  typedef logic [3:0]                       strb_t;
  typedef logic [$clog2(RobDepth)-1:0]      rob_id_t;
  typedef logic [$clog2(RobDepth+1)-1:0]    rob_cnt_t;
  typedef logic [$clog2(BankWords)-1:0]     bank_addr_t;
  typedef logic [$clog2(NumOutput)-1:0]     port_sel_t;

  localparam addr_t TcdmBase = 32'h0000_0000;
  localparam addr_t TcdmSize = 32'h0000_0800;

  typedef struct packed {
    addr_t   addr;
    logic    write;
    data_t   data;
    strb_t   strb;
    rob_id_t id;
  } dreq_t;

  typedef struct packed {
    data_t   data;
    rob_id_t id;
    logic    error;
  } dresp_t;

endpackage

// File: design/tcdm_shim.sv
/*
 * TCDM shim
 * Tags core requests, routes them to banks or SoC and reorders the answers
 */
`timescale 1ns/1ps

module tcdm_shim (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // Core side
  input  tcdm_pkg::addr_t                         data_qaddr_i,
  input  logic                                    data_qwrite_i,
  input  tcdm_pkg::data_t                         data_qdata_i,
  input  tcdm_pkg::strb_t                         data_qstrb_i,
  input  logic                                    data_qvalid_i,
  output logic                                    data_qready_o,
  output tcdm_pkg::data_t                         data_pdata_o,
  output logic                                    data_perror_o,
  output logic                                    data_pvalid_o,
  input  logic                                    data_pready_i,
  // SoC side
  output logic                                    soc_qvalid_o,
  output tcdm_pkg::addr_t                         soc_qaddr_o,
  output logic                                    soc_qwrite_o,
  output tcdm_pkg::data_t                         soc_qdata_o,
  output tcdm_pkg::strb_t                         soc_qstrb_o,
  output tcdm_pkg::rob_id_t                       soc_qid_o,
  input  logic                                    soc_qready_i,
  input  logic                                    soc_pvalid_i,
  input  tcdm_pkg::data_t                         soc_pdata_i,
  input  tcdm_pkg::rob_id_t                       soc_pid_i,
  input  logic                                    soc_perror_i,
  output logic                                    soc_pready_o,
  // Bank side
  output tcdm_pkg::dreq_t  [tcdm_pkg::NumBanks-1:0] bank_req_o,
  output logic             [tcdm_pkg::NumBanks-1:0] bank_req_valid_o,
  input  logic             [tcdm_pkg::NumBanks-1:0] bank_req_ready_i,
  input  tcdm_pkg::dresp_t [tcdm_pkg::NumBanks-1:0] bank_resp_i,
  input  logic             [tcdm_pkg::NumBanks-1:0] bank_resp_valid_i,
  output logic             [tcdm_pkg::NumBanks-1:0] bank_resp_ready_o
);

  tcdm_pkg::dreq_t                            data_qpayload;
  tcdm_pkg::dresp_t                           soc_ppayload;
  tcdm_pkg::dresp_t                           push_resp;
  tcdm_pkg::dresp_t                           rob_resp;
  tcdm_pkg::dreq_t  [tcdm_pkg::NumOutput-1:0] out_req;
  logic             [tcdm_pkg::NumOutput-1:0] out_valid;
  tcdm_pkg::dresp_t [tcdm_pkg::NumOutput-1:0] out_resp;
  logic             [tcdm_pkg::NumOutput-1:0] out_resp_ready;
  tcdm_pkg::rob_id_t                          rob_id;
  logic rob_full;
  logic rob_push;
  logic demux_ready;
  logic init_done_q;

  // Holds off requests until the first cycle after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      init_done_q <= 1'b0;
    end else begin
      init_done_q <= 1'b1;
    end
  end

  assign data_qpayload.addr  = data_qaddr_i;
  assign data_qpayload.write = data_qwrite_i;
  assign data_qpayload.data  = data_qdata_i;
  assign data_qpayload.strb  = data_qstrb_i;
  assign data_qpayload.id    = rob_id;

  assign data_qready_o = demux_ready && !rob_full && init_done_q;

  reorder_buffer i_reorder_buffer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .alloc_i     (data_qvalid_i && data_qready_o),
    .id_o        (rob_id),
    .full_o      (rob_full),
    .push_i      (rob_push),
    .push_resp_i (push_resp),
    .resp_o      (rob_resp),
    .valid_o     (data_pvalid_o),
    .pop_i       (data_pready_i)
  );

  assign data_pdata_o  = rob_resp.data;
  assign data_perror_o = rob_resp.error;

  addr_demux i_addr_demux (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_i            (data_qpayload),
    .req_valid_i      (data_qvalid_i && !rob_full && init_done_q),
    .req_ready_o      (demux_ready),
    .resp_o           (push_resp),
    .resp_valid_o     (rob_push),
    .out_req_o        (out_req),
    .out_valid_o      (out_valid),
    .out_ready_i      ({soc_qready_i, bank_req_ready_i}),
    .out_resp_i       (out_resp),
    .out_resp_valid_i ({soc_pvalid_i, bank_resp_valid_i}),
    .out_resp_ready_o (out_resp_ready)
  );

  assign soc_ppayload.data  = soc_pdata_i;
  assign soc_ppayload.id    = soc_pid_i;
  assign soc_ppayload.error = soc_perror_i;
  assign out_resp           = {soc_ppayload, bank_resp_i};

  assign bank_req_o        = out_req[tcdm_pkg::NumBanks-1:0];
  assign bank_req_valid_o  = out_valid[tcdm_pkg::NumBanks-1:0];
  assign bank_resp_ready_o = out_resp_ready[tcdm_pkg::NumBanks-1:0];

  assign soc_qvalid_o = out_valid[tcdm_pkg::SocPort];
  assign soc_qaddr_o  = out_req[tcdm_pkg::SocPort].addr;
  assign soc_qwrite_o = out_req[tcdm_pkg::SocPort].write;
  assign soc_qdata_o  = out_req[tcdm_pkg::SocPort].data;
  assign soc_qstrb_o  = out_req[tcdm_pkg::SocPort].strb;
  assign soc_qid_o    = out_req[tcdm_pkg::SocPort].id;
  assign soc_pready_o = out_resp_ready[tcdm_pkg::SocPort];

endmodule

// File: design/tcdm_subsystem.sv
/*
 * TCDM subsystem
 * Shim plus two interleaved banks, with core and SoC ports at the boundary
 */
`timescale 1ns/1ps

module tcdm_subsystem (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Core side
  input  tcdm_pkg::addr_t   data_qaddr_i,
  input  logic              data_qwrite_i,
  input  tcdm_pkg::data_t   data_qdata_i,
  input  tcdm_pkg::strb_t   data_qstrb_i,
  input  logic              data_qvalid_i,
  output logic              data_qready_o,
  output tcdm_pkg::data_t   data_pdata_o,
  output logic              data_perror_o,
  output logic              data_pvalid_o,
  input  logic              data_pready_i,
  // SoC side
  output logic              soc_qvalid_o,
  output tcdm_pkg::addr_t   soc_qaddr_o,
  output logic              soc_qwrite_o,
  output tcdm_pkg::data_t   soc_qdata_o,
  output tcdm_pkg::strb_t   soc_qstrb_o,
  output tcdm_pkg::rob_id_t soc_qid_o,
  input  logic              soc_qready_i,
  input  logic              soc_pvalid_i,
  input  tcdm_pkg::data_t   soc_pdata_i,
  input  tcdm_pkg::rob_id_t soc_pid_i,
  input  logic              soc_perror_i,
  output logic              soc_pready_o
);

  tcdm_pkg::dreq_t  [tcdm_pkg::NumBanks-1:0] bank_req;
  logic             [tcdm_pkg::NumBanks-1:0] bank_req_valid;
  logic             [tcdm_pkg::NumBanks-1:0] bank_req_ready;
  tcdm_pkg::dresp_t [tcdm_pkg::NumBanks-1:0] bank_resp;
  logic             [tcdm_pkg::NumBanks-1:0] bank_resp_valid;
  logic             [tcdm_pkg::NumBanks-1:0] bank_resp_ready;

  tcdm_shim i_tcdm_shim (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .data_qaddr_i      (data_qaddr_i),
    .data_qwrite_i     (data_qwrite_i),
    .data_qdata_i      (data_qdata_i),
    .data_qstrb_i      (data_qstrb_i),
    .data_qvalid_i     (data_qvalid_i),
    .data_qready_o     (data_qready_o),
    .data_pdata_o      (data_pdata_o),
    .data_perror_o     (data_perror_o),
    .data_pvalid_o     (data_pvalid_o),
    .data_pready_i     (data_pready_i),
    .soc_qvalid_o      (soc_qvalid_o),
    .soc_qaddr_o       (soc_qaddr_o),
    .soc_qwrite_o      (soc_qwrite_o),
    .soc_qdata_o       (soc_qdata_o),
    .soc_qstrb_o       (soc_qstrb_o),
    .soc_qid_o         (soc_qid_o),
    .soc_qready_i      (soc_qready_i),
    .soc_pvalid_i      (soc_pvalid_i),
    .soc_pdata_i       (soc_pdata_i),
    .soc_pid_i         (soc_pid_i),
    .soc_perror_i      (soc_perror_i),
    .soc_pready_o      (soc_pready_o),
    .bank_req_o        (bank_req),
    .bank_req_valid_o  (bank_req_valid),
    .bank_req_ready_i  (bank_req_ready),
    .bank_resp_i       (bank_resp),
    .bank_resp_valid_i (bank_resp_valid),
    .bank_resp_ready_o (bank_resp_ready)
  );

  for (genvar i = 0; i < tcdm_pkg::NumBanks; i++) begin : gen_bank
    tcdm_bank i_tcdm_bank (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (bank_req[i]),
      .req_valid_i  (bank_req_valid[i]),
      .req_ready_o  (bank_req_ready[i]),
      .resp_o       (bank_resp[i]),
      .resp_valid_o (bank_resp_valid[i]),
      .resp_ready_i (bank_resp_ready[i])
    );
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the TCDM subsystem testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_tcdm -f build.f -o sim_tb_tcdm
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_tcdm)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" <<< "$output"; then
  exit 0
fi
exit 1

// File: tb/tb_tcdm.sv
/*
 * TCDM subsystem testbench
 * Table-driven core requests, SoC target model and random core back-pressure
 */
`timescale 1ns/1ps

module tb_tcdm;

  localparam int unsigned NumReqs     = 24;
  localparam int unsigned ResetCycles = 4;

  typedef struct packed {
    logic            write;
    tcdm_pkg::addr_t addr;
    tcdm_pkg::data_t data;
    tcdm_pkg::strb_t strb;
  } stim_t;

  typedef struct packed {
    tcdm_pkg::rob_id_t id;
    tcdm_pkg::data_t   data;
    logic              error;
    logic [3:0]        delay;
  } soc_job_t;

  logic              clk;
  logic              rst_n;
  tcdm_pkg::addr_t   data_qaddr;
  logic              data_qwrite;
  tcdm_pkg::data_t   data_qdata;
  tcdm_pkg::strb_t   data_qstrb;
  logic              data_qvalid;
  logic              data_qready;
  tcdm_pkg::data_t   data_pdata;
  logic              data_perror;
  logic              data_pvalid;
  logic              data_pready;
  logic              soc_qvalid;
  tcdm_pkg::addr_t   soc_qaddr;
  logic              soc_qwrite;
  tcdm_pkg::data_t   soc_qdata;
  tcdm_pkg::strb_t   soc_qstrb;
  tcdm_pkg::rob_id_t soc_qid;
  logic              soc_qready;
  logic              soc_pvalid;
  tcdm_pkg::data_t   soc_pdata;
  tcdm_pkg::rob_id_t soc_pid;
  logic              soc_perror;
  logic              soc_pready;

  stim_t       stim [NumReqs];
  soc_job_t    soc_jobs [$];
  int unsigned next_idx = 0;
  logic [31:0] rng = 32'h25d3_65af;
  logic [1:0]  qwait = 2'd0;
  int unsigned errors;
  int unsigned resp_count;
  logic        done;
  logic        timed_out;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  tcdm_subsystem tcdm_subsystem_i (
    .clk_i (clk), .rst_n_i (rst_n),
    .data_qaddr_i (data_qaddr), .data_qwrite_i (data_qwrite), .data_qdata_i (data_qdata),
    .data_qstrb_i (data_qstrb), .data_qvalid_i (data_qvalid), .data_qready_o (data_qready),
    .data_pdata_o (data_pdata), .data_perror_o (data_perror), .data_pvalid_o (data_pvalid),
    .data_pready_i (data_pready),
    .soc_qvalid_o (soc_qvalid), .soc_qaddr_o (soc_qaddr), .soc_qwrite_o (soc_qwrite),
    .soc_qdata_o (soc_qdata), .soc_qstrb_o (soc_qstrb), .soc_qid_o (soc_qid),
    .soc_qready_i (soc_qready), .soc_pvalid_i (soc_pvalid), .soc_pdata_i (soc_pdata),
    .soc_pid_i (soc_pid), .soc_perror_i (soc_perror), .soc_pready_o (soc_pready)
  );

  tcdm_checker #(.NumReqs (NumReqs)) i_tcdm_checker (
    .clk_i (clk), .rst_n_i (rst_n),
    .data_qaddr_i (data_qaddr), .data_qwrite_i (data_qwrite), .data_qdata_i (data_qdata),
    .data_qstrb_i (data_qstrb), .data_qvalid_i (data_qvalid), .data_qready_i (data_qready),
    .data_pdata_i (data_pdata), .data_perror_i (data_perror), .data_pvalid_i (data_pvalid),
    .data_pready_i (data_pready), .soc_qvalid_i (soc_qvalid),
    .soc_qaddr_i (soc_qaddr), .soc_qwrite_i (soc_qwrite), .soc_qdata_i (soc_qdata),
    .soc_qstrb_i (soc_qstrb), .soc_qready_i (soc_qready),
    .errors_o (errors), .resp_count_o (resp_count), .done_o (done), .timeout_o (timed_out)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Next table entry once the previous one transferred
  always @(posedge clk) begin
    if (rst_n && (!data_qvalid || data_qready)) begin
      if (next_idx < NumReqs) begin
        data_qvalid <= 1'b1;
        data_qwrite <= stim[next_idx].write;
        data_qaddr  <= stim[next_idx].addr;
        data_qdata  <= stim[next_idx].data;
        data_qstrb  <= stim[next_idx].strb;
        next_idx    <= next_idx + 1;
      end else begin
        data_qvalid <= 1'b0;
      end
    end
  end

  // SoC target and core back-pressure share one random stream
  always @(posedge clk) begin
    soc_job_t job;
    int       found;
    if (rst_n) begin
      rng = xorshift(rng);
      data_pready <= (rng % 3) != 0;
      for (int i = 0; i < soc_jobs.size(); i++) begin
        if (soc_jobs[i].delay != 4'd0) begin
          soc_jobs[i].delay--;
        end
      end
      if (soc_pvalid && soc_pready) begin
        soc_pvalid <= 1'b0;
      end else if (!soc_pvalid) begin
        found = -1;
        for (int i = 0; i < soc_jobs.size(); i++) begin
          if (found < 0 && soc_jobs[i].delay == 4'd0) begin
            found = i;
          end
        end
        if (found >= 0) begin
          soc_pvalid <= 1'b1;
          soc_pid    <= soc_jobs[found].id;
          soc_pdata  <= soc_jobs[found].data;
          soc_perror <= soc_jobs[found].error;
          soc_jobs.delete(found);
        end
      end
      if (soc_qvalid && soc_qready) begin
        rng = xorshift(rng);
        job.id    = soc_qid;
        job.data  = soc_qwrite ? '0 : (soc_qaddr ^ 32'h5a5a_0000);
        job.error = soc_qaddr[3];
        job.delay = 4'd2 + {1'b0, rng[2:0]};
        soc_jobs.push_back(job);
        rng = xorshift(rng);
        soc_qready <= 1'b0;
        qwait      <= rng[1:0];
      end else if (qwait != 2'd0) begin
        qwait <= qwait - 2'd1;
      end else begin
        soc_qready <= 1'b1;
      end
    end
  end

  initial begin
    rst_n       = 1'b0;
    data_qaddr  = '0;
    data_qwrite = 1'b0;
    data_qdata  = '0;
    data_qstrb  = '0;
    data_qvalid = 1'b0;
    data_pready = 1'b0;
    soc_qready  = 1'b0;
    soc_pvalid  = 1'b0;
    soc_pdata   = '0;
    soc_pid     = '0;
    soc_perror  = 1'b0;

    // Full words, then partial strobes on words 0 and 1, then read back
    stim[0]  = '{1'b1, 32'h0000_0000, 32'h1122_3344, 4'b1111};
    stim[1]  = '{1'b1, 32'h0000_0004, 32'h5566_7788, 4'b1111};
    stim[2]  = '{1'b1, 32'h0000_0008, 32'h99aa_bbcc, 4'b1111};
    stim[3]  = '{1'b1, 32'h0000_000c, 32'hddee_ff00, 4'b1111};
    stim[4]  = '{1'b1, 32'h0000_0000, 32'ha5a5_a5a5, 4'b0101};
    stim[5]  = '{1'b1, 32'h0000_0004, 32'hc3c3_c3c3, 4'b1100};
    stim[6]  = '{1'b0, 32'h0000_0000, 32'h0, 4'b0000};
    stim[7]  = '{1'b0, 32'h0000_0004, 32'h0, 4'b0000};
    stim[8]  = '{1'b0, 32'h0000_0008, 32'h0, 4'b0000};
    stim[9]  = '{1'b0, 32'h0000_000c, 32'h0, 4'b0000};
    // SoC traffic mixed with bank reads, bit 3 selects the error
    stim[10] = '{1'b0, 32'h1000_0000, 32'h0, 4'b0000};
    stim[11] = '{1'b0, 32'h1000_0008, 32'h0, 4'b0000};
    stim[12] = '{1'b0, 32'h0000_0000, 32'h0, 4'b0000};
    stim[13] = '{1'b0, 32'h1000_0010, 32'h0, 4'b0000};
    stim[14] = '{1'b1, 32'h1000_0018, 32'h0bad_f00d, 4'b1111};
    stim[15] = '{1'b0, 32'h1000_0024, 32'h0, 4'b0000};
    stim[16] = '{1'b0, 32'h0000_0004, 32'h0, 4'b0000};
    stim[17] = '{1'b0, 32'h1000_0028, 32'h0, 4'b0000};
    stim[18] = '{1'b0, 32'h1000_0030, 32'h0, 4'b0000};
    stim[19] = '{1'b0, 32'h1000_003c, 32'h0, 4'b0000};
    stim[20] = '{1'b1, 32'h1000_0040, 32'h1234_5678, 4'b0011};
    // Just past the TCDM region
    stim[21] = '{1'b0, 32'h0000_0808, 32'h0, 4'b0000};
    stim[22] = '{1'b1, 32'h0000_07fc, 32'hdead_beef, 4'b1111};
    stim[23] = '{1'b0, 32'h0000_07fc, 32'h0, 4'b0000};

    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;

    while (!done && !timed_out) begin
      @(posedge clk);
    end
    // Room for a duplicate response to show up
    if (!timed_out) begin
      repeat (20) @(posedge clk);
    end

    $display("Errors: %0d, responses: %0d of %0d", errors, resp_count, NumReqs);
    if (errors == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: tb/tcdm_checker.sv
/*
 * TCDM subsystem checker
 * Predicts core responses from a reference memory and compares them in order
 */
`timescale 1ns/1ps

module tcdm_checker #(
  parameter int unsigned NumReqs = 24
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  tcdm_pkg::addr_t data_qaddr_i,
  input  logic            data_qwrite_i,
  input  tcdm_pkg::data_t data_qdata_i,
  input  tcdm_pkg::strb_t data_qstrb_i,
  input  logic            data_qvalid_i,
  input  logic            data_qready_i,
  input  tcdm_pkg::data_t data_pdata_i,
  input  logic            data_perror_i,
  input  logic            data_pvalid_i,
  input  logic            data_pready_i,
  input  logic            soc_qvalid_i,
  input  tcdm_pkg::addr_t soc_qaddr_i,
  input  logic            soc_qwrite_i,
  input  tcdm_pkg::data_t soc_qdata_i,
  input  tcdm_pkg::strb_t soc_qstrb_i,
  input  logic            soc_qready_i,
  output int unsigned     errors_o,
  output int unsigned     resp_count_o,
  output logic            done_o,
  output logic            timeout_o
);

  localparam int unsigned CycleLimit = NumReqs * 40 + 200;

  typedef struct packed {
    tcdm_pkg::data_t data;
    logic            error;
  } expect_t;

  typedef struct packed {
    tcdm_pkg::addr_t addr;
    logic            write;
    tcdm_pkg::data_t data;
    tcdm_pkg::strb_t strb;
  } soc_req_t;

  // One entry per word of the 2 KiB TCDM region
  tcdm_pkg::data_t ref_mem [512];
  expect_t         expect_q [$];
  soc_req_t        soc_req_q [$];
  int unsigned     err_count = 0;
  int unsigned     resp_count = 0;
  int unsigned     cycles_q = 0;
  logic            out_of_reset_q = 1'b0;
  logic            timed_out_q = 1'b0;

  assign errors_o     = err_count;
  assign resp_count_o = resp_count;
  assign done_o       = (resp_count == NumReqs);
  assign timeout_o    = timed_out_q;

  always @(posedge clk_i) begin
    expect_t     want;
    soc_req_t    sreq;
    logic [8:0]  widx;
    int unsigned err;
    err = err_count;
    cycles_q <= cycles_q + 1;

    if (!rst_n_i || !out_of_reset_q) begin
      if (data_pvalid_i || soc_qvalid_i || data_qready_i) begin
        $display("%0t: core response valid, SoC request valid or core ready high in reset",
                 $time);
        err++;
      end
      out_of_reset_q <= rst_n_i;
    end

    if (rst_n_i && data_qvalid_i && data_qready_i) begin
      if ((data_qaddr_i - tcdm_pkg::TcdmBase) < tcdm_pkg::TcdmSize) begin
        widx = data_qaddr_i[10:2];
        want = '{data: '0, error: 1'b0};
        if (data_qwrite_i) begin
          for (int b = 0; b < 4; b++) begin
            if (data_qstrb_i[b]) begin
              ref_mem[widx][8*b +: 8] = data_qdata_i[8*b +: 8];
            end
          end
        end else begin
          want.data = ref_mem[widx];
        end
      end else begin
        // SoC target answers with the address pattern, error on bit 3
        want.data  = data_qwrite_i ? '0 : (data_qaddr_i ^ 32'h5a5a_0000);
        want.error = data_qaddr_i[3];
        sreq.addr  = data_qaddr_i;
        sreq.write = data_qwrite_i;
        sreq.data  = data_qdata_i;
        sreq.strb  = data_qstrb_i;
        soc_req_q.push_back(sreq);
      end
      expect_q.push_back(want);
    end

    // SoC port carries the core request unchanged
    if (rst_n_i && soc_qvalid_i && soc_qready_i) begin
      if (soc_req_q.size() == 0) begin
        $display("%0t: SoC request sent with no core request routed to it", $time);
        err++;
      end else begin
        sreq = soc_req_q.pop_front();
        if (soc_qaddr_i !== sreq.addr || soc_qwrite_i !== sreq.write ||
            soc_qdata_i !== sreq.data || soc_qstrb_i !== sreq.strb) begin
          $display("mismatch at %0t: SoC request addr %h write %b data %h strb %b",
                   $time, soc_qaddr_i, soc_qwrite_i, soc_qdata_i, soc_qstrb_i);
          $display("  expected addr %h write %b data %h strb %b",
                   sreq.addr, sreq.write, sreq.data, sreq.strb);
          err++;
        end
      end
    end

    if (rst_n_i && data_pvalid_i && data_pready_i) begin
      if (expect_q.size() == 0) begin
        $display("%0t: core response arrived with no request outstanding", $time);
        err++;
      end else begin
        want = expect_q.pop_front();
        if (data_pdata_i !== want.data || data_perror_i !== want.error) begin
          $display("mismatch at %0t: response %0d data %h error %b, expected %h error %b",
                   $time, resp_count, data_pdata_i, data_perror_i, want.data, want.error);
          err++;
        end
      end
      resp_count <= resp_count + 1;
    end

    if (cycles_q == CycleLimit && !timed_out_q) begin
      $display("%0t: timeout after %0d cycles with %0d of %0d responses received",
               $time, cycles_q, resp_count, NumReqs);
      err++;
      timed_out_q <= 1'b1;
    end
    err_count <= err;
  end

endmodule
